// ==== flist.f ====
common/display_pkg.sv
hdl/bin_to_bcd.sv
hdl/digit_glyph.sv
playfield/play_layout.sv
playfield/over_layout.sv
hdl/video_display.sv
testbench/tb_video_display.sv

// ==== Bender.yml ====
package:
  name: video_display

sources:
  # shared package first
  - common/display_pkg.sv
  - hdl/bin_to_bcd.sv
  - hdl/digit_glyph.sv
  - playfield/play_layout.sv
  - playfield/over_layout.sv
  - hdl/video_display.sv

  - target: test
    files:
      - testbench/tb_video_display.sv

// ==== testbench/tb_video_display.sv ====
module tb_video_display;

    localparam logic [31:0] SEED        = 32'h909f_c5ff;
    localparam int          DRAIN_LIMIT = 8;        // cycles allowed to empty the pipeline

    // digits that light each segment, bit n for digit n
    localparam logic [9:0] DIGITS_A = 10'b1111101101;
    localparam logic [9:0] DIGITS_B = 10'b1110011111;
    localparam logic [9:0] DIGITS_C = 10'b1111111011;
    localparam logic [9:0] DIGITS_D = 10'b1101101101;
    localparam logic [9:0] DIGITS_E = 10'b0101000101;
    localparam logic [9:0] DIGITS_F = 10'b1101110001;
    localparam logic [9:0] DIGITS_G = 10'b1101111100;

    logic                            pixel_clk;
    logic                            arst_n;
    logic                            ini;
    logic                            en;
    logic [display_pkg::SLOT_W-1:0]  led;
    logic [display_pkg::ROUND_W-1:0] round;
    logic [display_pkg::POINT_W-1:0] point;
    logic [display_pkg::COORD_W-1:0] pixel_xpos;
    logic [display_pkg::COORD_W-1:0] pixel_ypos;
    logic [display_pkg::PIXEL_W-1:0] pixel_data;

    logic [31:0]                     lfsr_state;
    logic [display_pkg::PIXEL_W-1:0] exp_q[$];     // expected pixels in flight
    int                              x_q[$];
    int                              y_q[$];
    int                              check_count;
    int                              error_count;
    int                              test_checks0;  // counts at start of current test
    int                              test_errors0;

    video_display dut_i
    (
        .pixel_clk  (pixel_clk),
        .arst_n     (arst_n),
        .ini        (ini),
        .en         (en),
        .led        (led),
        .round      (round),
        .point      (point),
        .pixel_xpos (pixel_xpos),
        .pixel_ypos (pixel_ypos),
        .pixel_data (pixel_data)
    );

    initial
    begin
        pixel_clk = 1'b0;
        forever #2 pixel_clk = ~pixel_clk;
    end

    //////////////////////////////////////////////////
    // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_bits(16)) % n;
    endfunction

    //////////////////////////////////////////////////
    // pixel model
    function automatic logic segment_lit
    (
        input int d,
        input int u,
        input int v
    );
        logic mid_col;
        logic left_col;
        logic right_col;
        logic upper;
        if (d < 0 || d > 9 || u < 0 || u >= 32 || v < 0 || v >= 50)
            return 1'b0;                            // outside the cell or blank
        mid_col   = (u >= 4) && (u < 28);
        left_col  = (u < 4);
        right_col = (u >= 28);
        upper     = (v < 25);
        return (DIGITS_A[d] && mid_col && v < 4) ||
               (DIGITS_G[d] && mid_col && v >= 23 && v < 27) ||
               (DIGITS_D[d] && mid_col && v >= 46) ||
               (DIGITS_F[d] && left_col && upper) ||
               (DIGITS_E[d] && left_col && !upper) ||
               (DIGITS_B[d] && right_col && upper) ||
               (DIGITS_C[d] && right_col && !upper);
    endfunction

    function automatic logic [display_pkg::PIXEL_W-1:0] model_pixel
    (
        input logic                            ini_v,
        input logic                            en_v,
        input logic [display_pkg::SLOT_W-1:0]  led_v,
        input logic [display_pkg::ROUND_W-1:0] round_v,
        input logic [display_pkg::POINT_W-1:0] point_v,
        input int                              x,
        input int                              y
    );
        int tens_v;
        int ones_v;
        int top;
        int cx;
        int cy;
        tens_v = int'(point_v) / 10;
        ones_v = int'(point_v) % 10;
        if (ini_v)
            return (x >= 550 && x < 730 && y >= 330 && y < 390) ?
                   display_pkg::START_BLUE : display_pkg::WHITE;
        if (round_v == 2'd0 || !en_v)
        begin
            if (x >= 540 && x < 740 && y >= 160 && y < 360)
                return display_pkg::MOLE_BROWN;
            if (tens_v != 0 && segment_lit(tens_v, x - 672, y - 360))
                return display_pkg::INK;
            if (segment_lit(ones_v, x - 704, y - 360))
                return display_pkg::INK;
            return display_pkg::WHITE;
        end
        for (int k = 1; k <= 3; k++)
        begin
            if (x >= 320 * k - 2 && x < 320 * k + 1 && y < 641)
                return display_pkg::RED;
        end
        if ((y >= 318 && y < 321) || (y >= 638 && y < 641))
            return display_pkg::RED;
        if (led_v != 8'd0)
        begin
            top = 7;
            while (!led_v[top])
                top--;
            cx = 160 * (2 * (3 - top % 4) + 1);     // slot centre
            cy = (top < 4) ? 480 : 160;
            if (x >= cx - 100 && x < cx + 100 && y >= cy - 100 && y < cy + 100)
                return display_pkg::MOLE_BROWN;
        end
        if (segment_lit(int'(round_v), x - 320, y - 655))
            return display_pkg::INK;
        if (tens_v != 0 && segment_lit(tens_v, x - 960, y - 655))
            return display_pkg::INK;
        if (segment_lit(ones_v, x - 992, y - 655))
            return display_pkg::INK;
        return display_pkg::WHITE;
    endfunction

    //////////////////////////////////////////////////
    // drive, compare, report
    task automatic check_pixel
    (
        input logic [display_pkg::PIXEL_W-1:0] actual,
        input logic [display_pkg::PIXEL_W-1:0] expected,
        input int                              x,
        input int                              y
    );
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Mismatch at time %0t: pixel_data is %h, expected %h, pixel (%0d, %0d)",
                     $time, actual, expected, x, y);
        end
    endtask

    task automatic compare_oldest;
        logic [display_pkg::PIXEL_W-1:0] expected;
        int x;
        int y;
        expected = exp_q.pop_front();
        x = x_q.pop_front();
        y = y_q.pop_front();
        check_pixel(pixel_data, expected, x, y);
    endtask

    task automatic drive_pixel
    (
        input logic                            ini_v,
        input logic                            en_v,
        input logic [display_pkg::SLOT_W-1:0]  led_v,
        input logic [display_pkg::ROUND_W-1:0] round_v,
        input logic [display_pkg::POINT_W-1:0] point_v,
        input int                              x,
        input int                              y
    );
        @(negedge pixel_clk);
        if (exp_q.size() >= 2)
            compare_oldest();                       // driven two rising edges ago
        ini        = ini_v;
        en         = en_v;
        led        = led_v;
        round      = round_v;
        point      = point_v;
        pixel_xpos = display_pkg::COORD_W'(x);
        pixel_ypos = display_pkg::COORD_W'(y);
        exp_q.push_back(model_pixel(ini_v, en_v, led_v, round_v, point_v, x, y));
        x_q.push_back(x);
        y_q.push_back(y);
    endtask

    task automatic drain_pipeline;
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge pixel_clk);
            compare_oldest();
            waited++;
        end
        if (exp_q.size() > 0)
        begin
            error_count++;
            $display("pipeline still held %0d pixels after %0d cycles", exp_q.size(), waited);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        drain_pipeline();
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 check_count - test_checks0, error_count - test_errors0);
        test_checks0 = check_count;
        test_errors0 = error_count;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial
    begin
        int         x;
        int         y;
        logic       en_r;
        logic [1:0] round_r;
        logic [5:0] point_r;
        logic [7:0] led_r;

        lfsr_state   = SEED;
        check_count  = 0;
        error_count  = 0;
        test_checks0 = 0;
        test_errors0 = 0;
        arst_n       = 1'b0;
        ini          = 1'b1;
        en           = 1'b1;
        led          = 8'h04;                       // mole in row 1, column 1
        round        = 2'd1;
        point        = '0;
        pixel_xpos   = 11'd560;                     // inside the start box and the mole box
        pixel_ypos   = 11'd385;

        repeat (3)
        begin
            @(negedge pixel_clk);
            check_pixel(pixel_data, display_pkg::WHITE, 560, 385);
        end
        arst_n     = 1'b1;
        pixel_xpos = '0;                            // start screen, outside the box
        pixel_ypos = '0;
        repeat (2)
        begin
            @(negedge pixel_clk);
            check_pixel(pixel_data, display_pkg::WHITE, 0, 0);
        end
        finish_test(1, "reset");

        for (int i = 0; i < 316; i++)
        begin
            if (i < 16)
            begin
                x = (i % 4 < 2) ? 549 + i % 4 : 727 + i % 4;    // box edges and one outside
                y = (i / 4 < 2) ? 329 + i / 4 : 387 + i / 4;
            end
            else if (i % 2 == 0)
            begin
                x = 530 + rand_below(220);
                y = 310 + rand_below(100);
            end
            else
            begin
                x = rand_below(1280);
                y = rand_below(720);
            end
            drive_pixel(1'b1, 1'(rand_bits(1)), 8'(rand_bits(8)), 2'(rand_bits(2)),
                        6'(rand_bits(6)), x, y);
        end
        finish_test(2, "start screen");

        for (int i = 0; i < 600; i++)
        begin
            en_r    = 1'(rand_bits(1));
            round_r = 2'(rand_bits(2));
            if (i % 2 == 0)
                round_r = 2'd0;
            else
                en_r = 1'b0;
            point_r = (i % 4 == 0) ? 6'(rand_below(10)) : 6'(rand_bits(6));
            case (i % 3)
                0:
                begin
                    x = 672 + rand_below(64);       // score cells
                    y = 360 + rand_below(50);
                end
                1:
                begin
                    x = 530 + rand_below(220);
                    y = 150 + rand_below(270);
                end
                default:
                begin
                    x = rand_below(1280);
                    y = rand_below(720);
                end
            endcase
            drive_pixel(1'b0, en_r, 8'(rand_bits(8)), round_r, point_r, x, y);
        end
        finish_test(3, "game-over screen");

        for (int j = 0; j < 17; j++)
        begin
            if (j < 8)
                led_r = 8'd1 << j;
            else if (j == 8)
                led_r = 8'd0;
            else
                led_r = 8'(rand_bits(8)) | 8'd1;    // bit 0 plus random upper bits
            for (int i = 0; i < 120; i++)
            begin
                x = rand_below(1280);
                y = rand_below(660);
                if (i % 4 == 0)
                    x = 320 * (1 + rand_below(3)) - 4 + rand_below(8);
                else if (i % 4 == 1)
                    y = (rand_bits(1) ? 318 : 638) - 3 + rand_below(7);
                drive_pixel(1'b0, 1'b1, led_r, 2'(1 + rand_below(3)), 6'(rand_bits(6)), x, y);
            end
        end
        finish_test(4, "play grid and mole");

        for (int r = 1; r <= 3; r++)
        begin
            for (int v = 0; v < 50; v++)
            begin
                for (int u = 0; u < 32; u++)
                begin
                    drive_pixel(1'b0, 1'b1, 8'(rand_bits(8)), 2'(r), 6'(rand_bits(6)),
                                320 + u, 655 + v);
                end
            end
        end
        for (int p = 0; p < 64; p++)
        begin
            for (int v = 0; v < 50; v++)
            begin
                for (int u = 0; u < 64; u++)
                begin
                    drive_pixel(1'b0, 1'b1, 8'(rand_bits(8)), 2'(p % 3 + 1), 6'(p),
                                960 + u, 655 + v);
                end
            end
        end
        finish_test(5, "status digits");

        for (int i = 0; i < 3000; i++)
        begin
            en_r    = 1'b1;
            round_r = 2'(1 + rand_below(3));
            if (i % 3 == 1)
            begin
                if (rand_bits(1))
                    round_r = 2'd0;
                else
                    en_r = 1'b0;
            end
            x = rand_below(1280);
            y = (i % 4 == 3) ? 640 + rand_below(80) : rand_below(720);
            drive_pixel(i % 3 == 0, en_r, 8'(rand_bits(8)), round_r, 6'(rand_bits(6)), x, y);
        end
        finish_test(6, "streaming");

        $display("all tests done: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== hdl/video_display.sv ====
module video_display
(
    input  logic                            pixel_clk,
    input  logic                            arst_n,
    input  logic                            ini,
    input  logic                            en,
    input  logic [display_pkg::SLOT_W-1:0]  led,
    input  logic [display_pkg::ROUND_W-1:0] round,
    input  logic [display_pkg::POINT_W-1:0] point,
    input  logic [display_pkg::COORD_W-1:0] pixel_xpos,
    input  logic [display_pkg::COORD_W-1:0] pixel_ypos,
    output logic [display_pkg::PIXEL_W-1:0] pixel_data
);

    logic [display_pkg::TENS_W-1:0]  tens;
    logic [display_pkg::DIGIT_W-1:0] ones;

    logic                            play_grid_hit;
    logic                            play_mole_hit;
    logic                            play_digit_hit;
    logic [display_pkg::DIGIT_W-1:0] play_digit;
    logic [display_pkg::COORD_W-1:0] play_cell_x;
    logic [display_pkg::COORD_W-1:0] play_cell_y;

    logic                            over_mole_hit;
    logic                            over_digit_hit;
    logic [display_pkg::DIGIT_W-1:0] over_digit;
    logic [display_pkg::COORD_W-1:0] over_cell_x;
    logic [display_pkg::COORD_W-1:0] over_cell_y;

    logic                            show_start;    // stage 1 screen select
    logic                            show_over;
    logic                            start_hit;
    logic [display_pkg::DIGIT_W-1:0] glyph_digit;
    logic [display_pkg::COORD_W-1:0] glyph_x;
    logic [display_pkg::COORD_W-1:0] glyph_y;
    logic                            glyph_lit;

    bin_to_bcd u_bin_to_bcd
    (
        .point (point),
        .tens  (tens),
        .ones  (ones)
    );

    play_layout u_play_layout
    (
        .pixel_clk  (pixel_clk),
        .arst_n     (arst_n),
        .pixel_xpos (pixel_xpos),
        .pixel_ypos (pixel_ypos),
        .led        (led),
        .round      (round),
        .tens       (tens),
        .ones       (ones),
        .grid_hit   (play_grid_hit),
        .mole_hit   (play_mole_hit),
        .digit_hit  (play_digit_hit),
        .digit      (play_digit),
        .cell_x     (play_cell_x),
        .cell_y     (play_cell_y)
    );

    over_layout u_over_layout
    (
        .pixel_clk  (pixel_clk),
        .arst_n     (arst_n),
        .pixel_xpos (pixel_xpos),
        .pixel_ypos (pixel_ypos),
        .tens       (tens),
        .ones       (ones),
        .mole_hit   (over_mole_hit),
        .digit_hit  (over_digit_hit),
        .digit      (over_digit),
        .cell_x     (over_cell_x),
        .cell_y     (over_cell_y)
    );

    //////////////////////////////////////////////////
    // stage 1, screen select and start banner box
    always_ff @(posedge pixel_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            show_start <= 1'b0;
            show_over  <= 1'b0;
            start_hit  <= 1'b0;
        end
        else
        begin
            show_start <= ini;
            show_over  <= !ini && ((round == '0) || !en);   // game over
            start_hit  <= (pixel_xpos >= display_pkg::START_X0) &&
                          (pixel_xpos <  display_pkg::START_X0 + display_pkg::START_W) &&
                          (pixel_ypos >= display_pkg::START_Y0) &&
                          (pixel_ypos <  display_pkg::START_Y0 + display_pkg::START_H);
        end
    end

    //////////////////////////////////////////////////
    // stage 2, glyph lookup and colour
    assign glyph_digit = show_over ? over_digit  : play_digit;
    assign glyph_x     = show_over ? over_cell_x : play_cell_x;
    assign glyph_y     = show_over ? over_cell_y : play_cell_y;

    digit_glyph u_digit_glyph
    (
        .digit  (glyph_digit),
        .cell_x (glyph_x),
        .cell_y (glyph_y),
        .lit    (glyph_lit)
    );

    always_ff @(posedge pixel_clk or negedge arst_n)
    begin
        if (!arst_n)
            pixel_data <= display_pkg::WHITE;
        else if (show_start)
            pixel_data <= start_hit ? display_pkg::START_BLUE : display_pkg::WHITE;
        else if (show_over ? over_mole_hit : play_mole_hit)
            pixel_data <= display_pkg::MOLE_BROWN;
        else if (!show_over && play_grid_hit)
            pixel_data <= display_pkg::RED;           // layout keeps grid and mole exclusive
        else if ((show_over ? over_digit_hit : play_digit_hit) && glyph_lit)
            pixel_data <= display_pkg::INK;
        else
            pixel_data <= display_pkg::WHITE;
    end

endmodule

// ==== playfield/over_layout.sv ====
module over_layout
(
    input  logic                            pixel_clk,
    input  logic                            arst_n,
    input  logic [display_pkg::COORD_W-1:0] pixel_xpos,
    input  logic [display_pkg::COORD_W-1:0] pixel_ypos,
    input  logic [display_pkg::TENS_W-1:0]  tens,
    input  logic [display_pkg::DIGIT_W-1:0] ones,
    output logic                            mole_hit,
    output logic                            digit_hit,
    output logic [display_pkg::DIGIT_W-1:0] digit,
    output logic [display_pkg::COORD_W-1:0] cell_x,
    output logic [display_pkg::COORD_W-1:0] cell_y
);

    logic in_mole;
    logic in_score_row;
    logic in_tens;
    logic in_ones;

    assign in_mole = (pixel_xpos >= display_pkg::OVER_MOLE_X0) &&
                     (pixel_xpos <  display_pkg::OVER_MOLE_X0 + display_pkg::MOLE_W) &&
                     (pixel_ypos >= display_pkg::OVER_MOLE_Y0) &&
                     (pixel_ypos <  display_pkg::OVER_MOLE_Y0 + display_pkg::MOLE_H);

    assign in_score_row = (pixel_ypos >= display_pkg::OVER_SCORE_Y0) &&
                          (pixel_ypos <  display_pkg::OVER_SCORE_Y0 + display_pkg::CELL_H);

    assign in_tens = in_score_row && (pixel_xpos >= display_pkg::OVER_SCORE_X0) &&
                     (pixel_xpos < display_pkg::OVER_SCORE_X0 + display_pkg::CELL_W);
    assign in_ones = in_score_row &&
                     (pixel_xpos >= display_pkg::OVER_SCORE_X0 + display_pkg::CELL_W) &&
                     (pixel_xpos <  display_pkg::OVER_SCORE_X0 + 2 * display_pkg::CELL_W);

    //////////////////////////////////////////////////
    // stage 1 registers
    always_ff @(posedge pixel_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mole_hit  <= 1'b0;
            digit_hit <= 1'b0;
        end
        else
        begin
            mole_hit  <= in_mole;
            digit_hit <= in_tens || in_ones;
        end
    end

    always_ff @(posedge pixel_clk)
    begin
        if (in_tens)
        begin
            digit  <= (tens == '0) ? {display_pkg::DIGIT_W{1'b1}}   // leading zero stays blank
                                   : display_pkg::DIGIT_W'(tens);
            cell_x <= pixel_xpos - display_pkg::OVER_SCORE_X0;
        end
        else
        begin
            digit  <= ones;
            cell_x <= pixel_xpos - display_pkg::OVER_SCORE_X0 - display_pkg::CELL_W;
        end
        cell_y <= pixel_ypos - display_pkg::OVER_SCORE_Y0;
    end

endmodule

// ==== playfield/play_layout.sv ====
module play_layout
(
    input  logic                            pixel_clk,
    input  logic                            arst_n,
    input  logic [display_pkg::COORD_W-1:0] pixel_xpos,
    input  logic [display_pkg::COORD_W-1:0] pixel_ypos,
    input  logic [display_pkg::SLOT_W-1:0]  led,
    input  logic [display_pkg::ROUND_W-1:0] round,
    input  logic [display_pkg::TENS_W-1:0]  tens,
    input  logic [display_pkg::DIGIT_W-1:0] ones,
    output logic                            grid_hit,
    output logic                            mole_hit,
    output logic                            digit_hit,
    output logic [display_pkg::DIGIT_W-1:0] digit,
    output logic [display_pkg::COORD_W-1:0] cell_x,
    output logic [display_pkg::COORD_W-1:0] cell_y
);

    logic [1:0]                      mole_col;
    logic                            mole_row;
    logic [display_pkg::COORD_W-1:0] mole_x0;
    logic [display_pkg::COORD_W-1:0] mole_y0;
    logic                            in_grid;
    logic                            in_mole;
    logic                            in_status;     // status digit row
    logic                            in_round;
    logic                            in_tens;
    logic                            in_ones;
    logic [display_pkg::DIGIT_W-1:0] next_digit;
    logic [display_pkg::COORD_W-1:0] next_cell_x;

    //////////////////////////////////////////////////
    // mole slot from led, highest set bit wins
    always_comb
    begin
        mole_col = 2'd0;
        mole_row = 1'b0;
        for (int i = 0; i < display_pkg::SLOT_W; i++)
        begin
            if (led[i])
            begin
                mole_col = 2'(3 - (i % 4));     // bit 7 -> col 0, bit 4 -> col 3
                mole_row = (i < 4);              // low nibble is the bottom row
            end
        end
    end

    // box sits centred in its 320x320 slot
    assign mole_x0 = display_pkg::SLOT_PITCH * mole_col +
                     (display_pkg::SLOT_PITCH - display_pkg::MOLE_W) / 2;
    assign mole_y0 = display_pkg::SLOT_PITCH * mole_row +
                     (display_pkg::SLOT_PITCH - display_pkg::MOLE_H) / 2;

    //////////////////////////////////////////////////
    // element hit tests
    always_comb
    begin
        in_grid = 1'b0;
        for (int k = 1; k <= 3; k++)
        begin
            if ((pixel_xpos >= display_pkg::SLOT_PITCH * k - 2) &&
                (pixel_xpos <  display_pkg::SLOT_PITCH * k + 1) &&
                (pixel_ypos <  display_pkg::GRID_LINES_BOTTOM))
            begin
                in_grid = 1'b1;                  // vertical bars
            end
            if ((k < 3) &&
                (pixel_ypos >= display_pkg::SLOT_PITCH * k - 2) &&
                (pixel_ypos <  display_pkg::SLOT_PITCH * k + 1))
            begin
                in_grid = 1'b1;                  // horizontal bars, full width
            end
        end
    end

    assign in_mole = (|led) &&
                     (pixel_xpos >= mole_x0) && (pixel_xpos < mole_x0 + display_pkg::MOLE_W) &&
                     (pixel_ypos >= mole_y0) && (pixel_ypos < mole_y0 + display_pkg::MOLE_H);

    assign in_status = (pixel_ypos >= display_pkg::STATUS_Y0) &&
                       (pixel_ypos <  display_pkg::STATUS_Y0 + display_pkg::CELL_H);
    assign in_round  = in_status && (pixel_xpos >= display_pkg::ROUND_X0) &&
                       (pixel_xpos < display_pkg::ROUND_X0 + display_pkg::CELL_W);
    assign in_tens   = in_status && (pixel_xpos >= display_pkg::PLAY_SCORE_X0) &&
                       (pixel_xpos < display_pkg::PLAY_SCORE_X0 + display_pkg::CELL_W);
    assign in_ones   = in_status && (pixel_xpos >= display_pkg::PLAY_SCORE_X0 + display_pkg::CELL_W) &&
                       (pixel_xpos < display_pkg::PLAY_SCORE_X0 + 2 * display_pkg::CELL_W);

    // digit value and cell origin of whichever status cell is hit
    always_comb
    begin
        if (in_round)
        begin
            next_digit  = display_pkg::DIGIT_W'(round);
            next_cell_x = pixel_xpos - display_pkg::ROUND_X0;
        end
        else if (in_tens)
        begin
            next_digit  = (tens == '0) ? {display_pkg::DIGIT_W{1'b1}}    // blank code
                                       : display_pkg::DIGIT_W'(tens);
            next_cell_x = pixel_xpos - display_pkg::PLAY_SCORE_X0;
        end
        else
        begin
            next_digit  = ones;
            next_cell_x = pixel_xpos - display_pkg::PLAY_SCORE_X0 - display_pkg::CELL_W;
        end
    end

    //////////////////////////////////////////////////
    // stage 1 registers
    always_ff @(posedge pixel_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            grid_hit  <= 1'b0;
            mole_hit  <= 1'b0;
            digit_hit <= 1'b0;
        end
        else
        begin
            grid_hit  <= in_grid;
            mole_hit  <= in_mole && !in_grid;
            digit_hit <= (in_round || in_tens || in_ones) && !in_grid && !in_mole;
        end
    end

    always_ff @(posedge pixel_clk)
    begin
        digit  <= next_digit;
        cell_x <= next_cell_x;
        cell_y <= pixel_ypos - display_pkg::STATUS_Y0;
    end

endmodule

// ==== hdl/digit_glyph.sv ====
module digit_glyph
(
    input  logic [display_pkg::DIGIT_W-1:0] digit,
    input  logic [display_pkg::COORD_W-1:0] cell_x,
    input  logic [display_pkg::COORD_W-1:0] cell_y,
    output logic                            lit
);

    logic [6:0] seg_on;     // {a, b, c, d, e, f, g}
    logic [6:0] seg_area;   // pixel lies inside that segment, same order
    logic       col_mid;
    logic       col_left;
    logic       col_right;
    logic       row_upper;
    logic       row_lower;

    // standard seven-segment sets, codes above 9 stay dark
    always_comb
    begin
        case (digit)
            4'd0:    seg_on = 7'b1111110;
            4'd1:    seg_on = 7'b0110000;
            4'd2:    seg_on = 7'b1101101;
            4'd3:    seg_on = 7'b1111001;
            4'd4:    seg_on = 7'b0110011;
            4'd5:    seg_on = 7'b1011011;
            4'd6:    seg_on = 7'b1011111;
            4'd7:    seg_on = 7'b1110000;
            4'd8:    seg_on = 7'b1111111;
            4'd9:    seg_on = 7'b1111011;
            default: seg_on = 7'b0000000;
        endcase
    end

    assign col_mid   = (cell_x >= display_pkg::SEG_T) &&
                       (cell_x <  display_pkg::CELL_W - display_pkg::SEG_T);
    assign col_left  = (cell_x <  display_pkg::SEG_T);
    assign col_right = (cell_x >= display_pkg::CELL_W - display_pkg::SEG_T) &&
                       (cell_x <  display_pkg::CELL_W);
    assign row_upper = (cell_y <  display_pkg::SEG_SPLIT);
    assign row_lower = (cell_y >= display_pkg::SEG_SPLIT) && (cell_y < display_pkg::CELL_H);

    assign seg_area[6] = col_mid && (cell_y < display_pkg::SEG_T);                 // a
    assign seg_area[5] = col_right && row_upper;                                   // b
    assign seg_area[4] = col_right && row_lower;                                   // c
    assign seg_area[3] = col_mid && (cell_y >= display_pkg::CELL_H - display_pkg::SEG_T) &&
                         (cell_y < display_pkg::CELL_H);                           // d
    assign seg_area[2] = col_left && row_lower;                                    // e
    assign seg_area[1] = col_left && row_upper;                                    // f
    assign seg_area[0] = col_mid && (cell_y >= display_pkg::MID_Y0) &&
                         (cell_y < display_pkg::MID_Y0 + display_pkg::SEG_T);      // g

    assign lit = |(seg_on & seg_area);

endmodule

// ==== hdl/bin_to_bcd.sv ====
module bin_to_bcd
(
    input  logic [display_pkg::POINT_W-1:0] point,
    output logic [display_pkg::TENS_W-1:0]  tens,
    output logic [display_pkg::DIGIT_W-1:0] ones
);

    logic [display_pkg::TENS_W+display_pkg::DIGIT_W-1:0] bcd;   // {tens, ones}

    // double dabble, one input bit per step
    // the tens nibble stays below 5 before the last shift for a 6-bit input,
    // so only the ones nibble ever needs the add-3 correction
    always_comb
    begin
        bcd = '0;
        for (int i = display_pkg::POINT_W - 1; i >= 0; i--)
        begin
            if (bcd[display_pkg::DIGIT_W-1:0] >= 4'd5)
            begin
                bcd[display_pkg::DIGIT_W-1:0] = bcd[display_pkg::DIGIT_W-1:0] + 4'd3;
            end
            bcd = {bcd[display_pkg::TENS_W+display_pkg::DIGIT_W-2:0], point[i]};
        end
    end

    assign tens = bcd[display_pkg::DIGIT_W +: display_pkg::TENS_W];
    assign ones = bcd[display_pkg::DIGIT_W-1:0];

endmodule

// ==== common/display_pkg.sv ====
package display_pkg;

    //////////////////////////////////////////////////
    // widths
    localparam int COORD_W = 11;                    // pixel coordinate
    localparam int PIXEL_W = 24;                    // rgb888 word
    localparam int SLOT_W  = 8;                     // one bit per mole slot
    localparam int ROUND_W = 2;
    localparam int POINT_W = 6;
    localparam int TENS_W  = 3;                     // tens of 0..63 fit in 3 bits
    localparam int DIGIT_W = 4;

    //////////////////////////////////////////////////
    // screen and digit cell
    localparam logic [COORD_W-1:0] H_DISP    = 11'd1280;
    localparam logic [COORD_W-1:0] V_DISP    = 11'd720;
    localparam logic [COORD_W-1:0] CELL_W    = 11'd32;
    localparam logic [COORD_W-1:0] CELL_H    = 11'd50;
    localparam logic [COORD_W-1:0] SEG_T     = 11'd4;   // segment thickness
    localparam logic [COORD_W-1:0] SEG_SPLIT = 11'd25;  // upper/lower half
    localparam logic [COORD_W-1:0] MID_Y0    = 11'd23;  // top row of segment g

    // play screen, a 4x2 grid of 320 pixel slots
    localparam logic [COORD_W-1:0] SLOT_PITCH        = H_DISP / 4;
    localparam logic [COORD_W-1:0] GRID_LINES_BOTTOM = 2 * SLOT_PITCH + 1;
    localparam logic [COORD_W-1:0] MOLE_W            = 11'd200;
    localparam logic [COORD_W-1:0] MOLE_H            = 11'd200;
    localparam logic [COORD_W-1:0] STATUS_Y0         = 11'd655;
    localparam logic [COORD_W-1:0] ROUND_X0          = 11'd320;
    localparam logic [COORD_W-1:0] PLAY_SCORE_X0     = 11'd960;

    // game-over screen
    localparam logic [COORD_W-1:0] OVER_MOLE_X0  = 11'd540;
    localparam logic [COORD_W-1:0] OVER_MOLE_Y0  = 11'd160;
    localparam logic [COORD_W-1:0] OVER_SCORE_X0 = 11'd672;
    localparam logic [COORD_W-1:0] OVER_SCORE_Y0 = 11'd360;

    // start screen, banner box centred on the display
    localparam logic [COORD_W-1:0] START_W  = 11'd180;
    localparam logic [COORD_W-1:0] START_H  = 11'd60;
    localparam logic [COORD_W-1:0] START_X0 = H_DISP / 2 - START_W / 2;
    localparam logic [COORD_W-1:0] START_Y0 = V_DISP / 2 - START_H / 2;

    //////////////////////////////////////////////////
    // colours
    localparam logic [PIXEL_W-1:0] WHITE      = 24'hffffff;
    localparam logic [PIXEL_W-1:0] RED        = 24'hff0c00;
    localparam logic [PIXEL_W-1:0] MOLE_BROWN = 24'h8b4513;
    localparam logic [PIXEL_W-1:0] START_BLUE = 24'h2050c0;
    localparam logic [PIXEL_W-1:0] INK        = 24'h000000;

endpackage
